//--- include/solver_defines.svh
// widths and sizes for the banded solver, included by the package, the RTL and the testbench
`ifndef SOLVER_DEFINES_SVH
`define SOLVER_DEFINES_SVH

// one unknown or one b entry, signed
`define X_WIDTH 24

// band coefficient c1..c3, signed
`define COEF_WIDTH 12

// accumulator for b minus six products, no overflow possible
`define ACC_WIDTH 40

// unknowns per system, also ring slots
`define N_UNKNOWNS 16

// diagonal is 2**DIAG_SHIFT
`define DIAG_SHIFT 4

// credits granted by the consumer after reset
`define OUT_CREDITS 4

`endif

//--- verilog/solver_pkg.sv
// shared data types and controller states for the banded solver; compile before the RTL
`default_nettype none

`include "solver_defines.svh"

package solver_pkg;

        // unknown or b value
        typedef logic signed [`X_WIDTH-1:0] x_t;

        // band coefficient
        typedef logic signed [`COEF_WIDTH-1:0] coef_t;

        // wide signed sum
        typedef logic signed [`ACC_WIDTH-1:0] acc_t;

        typedef logic [$clog2(`N_UNKNOWNS)-1:0] idx_t;
        typedef logic [3:0] sweeps_t;

        // holds 0..OUT_CREDITS
        typedef logic [$clog2(`OUT_CREDITS+1)-1:0] credit_t;

        typedef enum logic [1:0] {
                S_IDLE,
                S_SWEEP,
                S_DRAIN
        } solver_state_t;

endpackage

`default_nettype wire

//--- verilog/step_counter.sv
// index, phase and remaining-sweep counter; idx also serves as the b load address when idle
`default_nettype none

module step_counter (
        input  wire logic                clk,
        input  wire logic                rst,
        input  wire logic                clear_i,
        input  wire logic                step_en_i,
        input  wire logic                load_en_i,
        input  wire solver_pkg::sweeps_t sweeps_i,
        output solver_pkg::idx_t         idx_o,
        output logic [1:0]               phase_o,
        output logic                     last_update_o,
        output logic                     sweeps_done_o
);

        import solver_pkg::*;

        idx_t       idx_q;
        logic [1:0] phase_q;
        sweeps_t    sweeps_q;

        always_ff @(posedge clk) begin
                if (rst) begin
                        idx_q    <= '0;
                        phase_q  <= '0;
                        sweeps_q <= '0;
                end else if (clear_i) begin
                        idx_q    <= '0;
                        phase_q  <= '0;
                        sweeps_q <= sweeps_i;
                end else if (step_en_i) begin
                        if (phase_q == 2'd2) begin
                                phase_q <= '0;
                                // idx wraps to 0 on its own at the sweep end
                                idx_q   <= idx_q + 1'b1;
                                if (last_update_o) begin
                                        sweeps_q <= sweeps_q - 1'b1;
                                end
                        end else begin
                                phase_q <= phase_q + 1'b1;
                        end
                end else if (load_en_i) begin
                        // b load address, wraps at 16
                        idx_q <= idx_q + 1'b1;
                end
        end

        assign idx_o   = idx_q;
        assign phase_o = phase_q;

        // write cycle of x[15]
        assign last_update_o = (idx_q == '1) && (phase_q == 2'd2);

        // current sweep is the final one
        assign sweeps_done_o = sweeps_q <= sweeps_t'(1);

endmodule

`default_nettype wire

//--- verilog/x_ring.sv
// rotating ring of unknowns with neighbour taps; slot 0 is the current target or drain word
`default_nettype none

`include "solver_defines.svh"

module x_ring (
        input  wire logic         clk,
        input  wire logic         rst,
        input  wire logic         write_i,
        input  wire logic         drain_i,
        input  wire solver_pkg::x_t x_new_i,
        output solver_pkg::x_t    x_cur_o,
        output solver_pkg::x_t    p1_o,
        output solver_pkg::x_t    p2_o,
        output solver_pkg::x_t    p3_o,
        output solver_pkg::x_t    m1_o,
        output solver_pkg::x_t    m2_o,
        output solver_pkg::x_t    m3_o
);

        import solver_pkg::*;

        localparam int LAST = `N_UNKNOWNS - 1;

        x_t ring_q [`N_UNKNOWNS];

        // rotate towards slot 0 on either write or drain
        // on write the old target is replaced by its update in the last slot,
        // which makes it m1 of the next index
        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < `N_UNKNOWNS; i++) begin
                                ring_q[i] <= '0;
                        end
                end else if (write_i || drain_i) begin
                        for (int i = 0; i < LAST; i++) begin
                                ring_q[i] <= ring_q[i+1];
                        end
                        ring_q[LAST] <= write_i ? x_new_i : ring_q[0];
                end
        end

        assign x_cur_o = ring_q[0];

        // later unknowns, still from the previous sweep
        assign p1_o = ring_q[1];
        assign p2_o = ring_q[2];
        assign p3_o = ring_q[3];

        // earlier unknowns, already updated in this sweep
        assign m1_o = ring_q[LAST];
        assign m2_o = ring_q[LAST-1];
        assign m3_o = ring_q[LAST-2];

        // controller issues one rotation kind per cycle
        a_one_rotation: assert property (
                @(posedge clk) disable iff (rst)
                !(write_i && drain_i)
        );

endmodule

`default_nettype wire

//--- verilog/update_unit.sv
// b store and two-stage Gauss-Seidel update datapath; x_new is valid from phase 2 of an update
`default_nettype none

`include "solver_defines.svh"

module update_unit (
        input  wire logic              clk,
        input  wire logic              rst,
        input  wire logic              b_we_i,
        input  wire solver_pkg::idx_t  b_waddr_i,
        input  wire solver_pkg::x_t    b_data_i,
        input  wire solver_pkg::idx_t  idx_i,
        input  wire logic [1:0]        phase_i,
        input  wire solver_pkg::coef_t c1_i,
        input  wire solver_pkg::coef_t c2_i,
        input  wire solver_pkg::coef_t c3_i,
        input  wire solver_pkg::x_t    p1_i,
        input  wire solver_pkg::x_t    p2_i,
        input  wire solver_pkg::x_t    p3_i,
        input  wire solver_pkg::x_t    m1_i,
        input  wire solver_pkg::x_t    m2_i,
        input  wire solver_pkg::x_t    m3_i,
        output solver_pkg::x_t         x_new_o
);

        import solver_pkg::*;

        localparam int HI_BITS = `ACC_WIDTH - `X_WIDTH + 1;

        x_t b_mem [`N_UNKNOWNS];

        // symmetric band, so one multiply per neighbour pair
        logic signed [`X_WIDTH:0] pair1, pair2, pair3;
        acc_t prod1_q, prod2_q, prod3_q;
        acc_t sum, shifted;
        logic fits;
        x_t   x_sat;
        x_t   x_new_q;

        always_ff @(posedge clk) begin
                if (b_we_i) begin
                        b_mem[b_waddr_i] <= b_data_i;
                end
        end

        assign pair1 = p1_i + m1_i;
        assign pair2 = p2_i + m2_i;
        assign pair3 = p3_i + m3_i;

        // stage 1 in phase 0
        always_ff @(posedge clk) begin
                if (phase_i == 2'd0) begin
                        prod1_q <= c1_i * pair1;
                        prod2_q <= c2_i * pair2;
                        prod3_q <= c3_i * pair3;
                end
        end

        // stage 2: b minus band terms, floor divide by the diagonal
        assign sum     = acc_t'(b_mem[idx_i]) - prod1_q - prod2_q - prod3_q;
        assign shifted = sum >>> `DIAG_SHIFT;

        // in range when all bits above the x sign bit copy the sign
        assign fits = shifted[`ACC_WIDTH-1:`X_WIDTH-1] == {HI_BITS{shifted[`ACC_WIDTH-1]}};

        always_comb begin
                if (fits) begin
                        x_sat = shifted[`X_WIDTH-1:0];
                end else if (shifted[`ACC_WIDTH-1]) begin
                        x_sat = {1'b1, {(`X_WIDTH-1){1'b0}}};
                end else begin
                        x_sat = {1'b0, {(`X_WIDTH-1){1'b1}}};
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        x_new_q <= '0;
                end else if (phase_i == 2'd1) begin
                        x_new_q <= x_sat;
                end
        end

        // ring picks this up in phase 2
        assign x_new_o = x_new_q;

endmodule

`default_nettype wire

//--- verilog/sweep_ctrl.sv
// solver FSM for idle, sweeping and draining, with coefficient capture and output credits
`default_nettype none

`include "solver_defines.svh"

module sweep_ctrl (
        input  wire logic                clk,
        input  wire logic                rst,
        input  wire logic                start_i,
        input  wire solver_pkg::sweeps_t sweeps_i,
        input  wire solver_pkg::coef_t   c1_i,
        input  wire solver_pkg::coef_t   c2_i,
        input  wire solver_pkg::coef_t   c3_i,
        input  wire logic                b_valid_i,
        input  wire logic                credit_i,
        input  wire logic [1:0]          phase_i,
        input  wire logic                last_update_i,
        input  wire logic                sweeps_done_i,
        output logic                     clear_o,
        output logic                     step_en_o,
        output logic                     load_en_o,
        output logic                     ring_write_o,
        output logic                     ring_drain_o,
        output logic                     result_valid_o,
        output logic                     busy_o,
        output solver_pkg::coef_t        c1_o,
        output solver_pkg::coef_t        c2_o,
        output solver_pkg::coef_t        c3_o
);

        import solver_pkg::*;

        solver_state_t state_q, state_d;
        credit_t       credits_q;
        idx_t          drain_cnt_q;
        coef_t         c1_q, c2_q, c3_q;

        logic last_word;

        assign last_word = result_valid_o && (drain_cnt_q == idx_t'(`N_UNKNOWNS-1));

        always_comb begin
                state_d = state_q;
                case (state_q)
                        S_IDLE: begin
                                // zero sweeps drains the ring as it stands
                                if (start_i) begin
                                        state_d = (sweeps_i == '0) ? S_DRAIN : S_SWEEP;
                                end
                        end
                        S_SWEEP: begin
                                if (last_update_i && sweeps_done_i) begin
                                        state_d = S_DRAIN;
                                end
                        end
                        S_DRAIN: begin
                                if (last_word) begin
                                        state_d = S_IDLE;
                                end
                        end
                        default: state_d = S_IDLE;
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        state_q     <= S_IDLE;
                        credits_q   <= credit_t'(`OUT_CREDITS);
                        drain_cnt_q <= '0;
                end else begin
                        state_q <= state_d;
                        // spend and return may land in the same cycle
                        credits_q <= credits_q + credit_t'(credit_i)
                                     - credit_t'(result_valid_o);
                        // wraps back to 0 after the 16th word
                        if (result_valid_o) begin
                                drain_cnt_q <= drain_cnt_q + 1'b1;
                        end
                end
        end

        // run coefficients, held for the whole run
        always_ff @(posedge clk) begin
                if (clear_o) begin
                        c1_q <= c1_i;
                        c2_q <= c2_i;
                        c3_q <= c3_i;
                end
        end

        assign clear_o      = (state_q == S_IDLE) && start_i;
        assign load_en_o    = (state_q == S_IDLE) && b_valid_i;
        assign step_en_o    = state_q == S_SWEEP;
        assign ring_write_o = step_en_o && (phase_i == 2'd2);

        // ring holds still while out of credits
        assign result_valid_o = (state_q == S_DRAIN) && (credits_q != '0);
        assign ring_drain_o   = result_valid_o;
        assign busy_o         = state_q != S_IDLE;

        assign c1_o = c1_q;
        assign c2_o = c2_q;
        assign c3_o = c3_q;

        a_credit_max: assert property (
                @(posedge clk) disable iff (rst)
                credits_q <= credit_t'(`OUT_CREDITS)
        );

endmodule

`default_nettype wire

//--- verilog/band_solver.sv
// top of the periodic banded Gauss-Seidel solver; host loads b, starts, then takes x under credits
`default_nettype none

module band_solver (
        input  wire logic                clk,
        input  wire logic                rst,
        input  wire logic                b_valid_i,
        input  wire solver_pkg::x_t      b_data_i,
        input  wire logic                start_i,
        input  wire solver_pkg::sweeps_t sweeps_i,
        input  wire solver_pkg::coef_t   c1_i,
        input  wire solver_pkg::coef_t   c2_i,
        input  wire solver_pkg::coef_t   c3_i,
        input  wire logic                credit_i,
        output logic                     result_valid_o,
        output solver_pkg::x_t           result_data_o,
        output logic                     busy_o
);

        import solver_pkg::*;

        logic       clear, step_en, load_en, ring_write, ring_drain;
        logic       last_update, sweeps_done;
        logic [1:0] phase;
        idx_t       idx;
        coef_t      c1, c2, c3;
        x_t         x_cur, p1, p2, p3, m1, m2, m3, x_new;

        sweep_ctrl i_sweep_ctrl (
                .clk            (clk),
                .rst            (rst),
                .start_i        (start_i),
                .sweeps_i       (sweeps_i),
                .c1_i           (c1_i),
                .c2_i           (c2_i),
                .c3_i           (c3_i),
                .b_valid_i      (b_valid_i),
                .credit_i       (credit_i),
                .phase_i        (phase),
                .last_update_i  (last_update),
                .sweeps_done_i  (sweeps_done),
                .clear_o        (clear),
                .step_en_o      (step_en),
                .load_en_o      (load_en),
                .ring_write_o   (ring_write),
                .ring_drain_o   (ring_drain),
                .result_valid_o (result_valid_o),
                .busy_o         (busy_o),
                .c1_o           (c1),
                .c2_o           (c2),
                .c3_o           (c3)
        );

        step_counter i_step_counter (
                .clk           (clk),
                .rst           (rst),
                .clear_i       (clear),
                .step_en_i     (step_en),
                .load_en_i     (load_en),
                .sweeps_i      (sweeps_i),
                .idx_o         (idx),
                .phase_o       (phase),
                .last_update_o (last_update),
                .sweeps_done_o (sweeps_done)
        );

        x_ring i_x_ring (
                .clk     (clk),
                .rst     (rst),
                .write_i (ring_write),
                .drain_i (ring_drain),
                .x_new_i (x_new),
                .x_cur_o (x_cur),
                .p1_o    (p1),
                .p2_o    (p2),
                .p3_o    (p3),
                .m1_o    (m1),
                .m2_o    (m2),
                .m3_o    (m3)
        );

        // idx is the load address while idle and the update index while sweeping
        update_unit i_update_unit (
                .clk       (clk),
                .rst       (rst),
                .b_we_i    (load_en),
                .b_waddr_i (idx),
                .b_data_i  (b_data_i),
                .idx_i     (idx),
                .phase_i   (phase),
                .c1_i      (c1),
                .c2_i      (c2),
                .c3_i      (c3),
                .p1_i      (p1),
                .p2_i      (p2),
                .p3_i      (p3),
                .m1_i      (m1),
                .m2_i      (m2),
                .m3_i      (m3),
                .x_new_o   (x_new)
        );

        assign result_data_o = x_cur;

endmodule

`default_nettype wire

//--- dv/band_solver_tb.sv
// directed testbench for band_solver; reference Gauss-Seidel model plus a credit-returning consumer
`default_nettype none

`include "solver_defines.svh"

module band_solver_tb;

        timeunit 1ns;
        timeprecision 1ps;

        import solver_pkg::*;

        localparam int     N         = `N_UNKNOWNS;
        localparam longint X_MAX     = (longint'(1) <<< (`X_WIDTH - 1)) - 1;
        localparam longint X_MIN     = -(longint'(1) <<< (`X_WIDTH - 1));
        localparam int     RUN_LIMIT = 2000;

        logic    clk, rst, b_valid_i, start_i, credit_i;
        logic    result_valid_o, busy_o;
        x_t      b_data_i, result_data_o;
        sweeps_t sweeps_i;
        coef_t   c1_i, c2_i, c3_i;

        // model state carries over between runs, like the ring
        longint x_model [N];
        longint b_model [N];
        longint b_next [N];
        x_t     got [N];
        int     first_valid, max_outstanding;
        int     error_count, errors_before, tests_run, tests_failed;
        logic   timed_out;

        band_solver i_band_solver (.*);

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        // in place, so x[i-k] are already this sweep's values
        task automatic model_sweeps(input int sweeps, input int c1, input int c2, input int c3);
                longint acc;
                for (int s = 0; s < sweeps; s++) begin
                        for (int i = 0; i < N; i++) begin
                                acc = b_model[i]
                                      - c1 * (x_model[(i + 1) % N] + x_model[(i + N - 1) % N])
                                      - c2 * (x_model[(i + 2) % N] + x_model[(i + N - 2) % N])
                                      - c3 * (x_model[(i + 3) % N] + x_model[(i + N - 3) % N]);
                                // floor division by the diagonal
                                acc = acc >>> `DIAG_SHIFT;
                                if (acc > X_MAX) acc = X_MAX;
                                if (acc < X_MIN) acc = X_MIN;
                                x_model[i] = acc;
                        end
                end
        endtask

        // stream b_next in, load index starts at 0
        task automatic load_b();
                for (int i = 0; i < N; i++) begin
                        @(negedge clk);
                        b_valid_i  = 1'b1;
                        b_data_i   = x_t'(b_next[i]);
                        b_model[i] = b_next[i];
                end
                @(negedge clk);
                b_valid_i = 1'b0;
        endtask

        // consumer, credits go back credit_delay cycles after each word
        task automatic collect_results(input int credit_delay, input int stray_at);
                int cycle;
                int received;
                int returned;
                int due [$];
                cycle           = 0;
                received        = 0;
                returned        = 0;
                first_valid     = -1;
                max_outstanding = 0;
                while (returned < N) begin
                        @(negedge clk);
                        cycle++;
                        start_i  = 1'b0;
                        credit_i = 1'b0;
                        // stray start with other settings, must be ignored
                        if (cycle == stray_at) begin
                                start_i  = 1'b1;
                                sweeps_i = sweeps_t'(5);
                                c1_i     = coef_t'(7);
                        end
                        if (result_valid_o) begin
                                if (first_valid < 0) first_valid = cycle;
                                assert (received - returned < `OUT_CREDITS) else begin
                                        $display("more than %0d words arrived without a credit",
                                                 `OUT_CREDITS);
                                        error_count++;
                                end
                                assert (received < N) else begin
                                        $display("a result word arrived beyond the 16th");
                                        error_count++;
                                end
                                if (received < N) got[received] = result_data_o;
                                received++;
                                if (received - returned > max_outstanding) begin
                                        max_outstanding = received - returned;
                                end
                                due.push_back(cycle + credit_delay);
                        end
                        if (due.size() > 0 && due[0] <= cycle) begin
                                void'(due.pop_front());
                                credit_i = 1'b1;
                                returned++;
                        end
                        if (cycle > RUN_LIMIT) begin
                                $display("timeout, only %0d of 16 result words arrived", received);
                                timed_out = 1'b1;
                                break;
                        end
                end
                @(negedge clk);
                credit_i = 1'b0;
        endtask

        // start a run, then compare all 16 words and the return to idle
        task automatic run_and_check(input int sweeps, input int c1, input int c2, input int c3,
                                     input int credit_delay, input int stray_at);
                int n;
                @(negedge clk);
                sweeps_i = sweeps_t'(sweeps);
                c1_i     = coef_t'(c1);
                c2_i     = coef_t'(c2);
                c3_i     = coef_t'(c3);
                start_i  = 1'b1;
                model_sweeps(sweeps, c1, c2, c3);
                collect_results(credit_delay, stray_at);
                if (!timed_out) begin
                        for (int i = 0; i < N; i++) begin
                                assert (longint'(got[i]) == x_model[i]) else begin
                                        $display("MISMATCH result_data_o[%0d] got 0x%h exp 0x%h",
                                                 i, got[i], x_t'(x_model[i]));
                                        error_count++;
                                end
                        end
                        n = 0;
                        while (busy_o && n < 4) begin
                                @(negedge clk);
                                n++;
                        end
                        assert (!busy_o) else begin
                                $display("busy_o is still high after the last result word");
                                error_count++;
                        end
                end
        endtask

        task automatic report_test(input string name);
                tests_run++;
                if (error_count != errors_before || timed_out) begin
                        tests_failed++;
                        $display("%s: FAILED with %0d errors", name, error_count - errors_before);
                end else begin
                        $display("%s: ok", name);
                end
                errors_before = error_count;
        endtask

        task automatic test_zero_sweeps();
                run_and_check(0, 0, 0, 0, 0, -1);
                assert (timed_out || first_valid == 1) else begin
                        $display("MISMATCH first result_valid_o cycle got 0x%0h expected 0x1",
                                 first_valid);
                        error_count++;
                end
                report_test("zero sweeps after reset");
        endtask

        // distinct b, wrap neighbours of x[0] and x[15] all differ
        task automatic test_one_sweep();
                for (int i = 0; i < N; i++) b_next[i] = (i - 7) * 90001 + i * i * 313;
                load_b();
                run_and_check(1, 3, -2, 1, 0, -1);
                assert (timed_out || first_valid == 49) else begin
                        $display("MISMATCH first result_valid_o cycle got 0x%0h expected 0x31",
                                 first_valid);
                        error_count++;
                end
                report_test("one sweep, known b");
        endtask

        // negative band terms make the iteration grow into the limits
        task automatic test_saturation();
                int sat;
                sat = 0;
                for (int i = 0; i < N; i++) begin
                        b_next[i] = longint'($urandom_range(24'h7fffff, 24'h400000));
                end
                load_b();
                run_and_check(10, -int'($urandom_range(12, 6)), -int'($urandom_range(12, 6)),
                              -int'($urandom_range(12, 6)), 0, -1);
                for (int i = 0; i < N; i++) begin
                        if (longint'(got[i]) == X_MAX || longint'(got[i]) == X_MIN) sat++;
                end
                assert (timed_out || sat > 0) else begin
                        $display("no result word reached the saturation limits");
                        error_count++;
                end
                report_test("several sweeps, saturation");
        endtask

        task automatic load_random_b();
                for (int i = 0; i < N; i++) begin
                        b_next[i] = longint'($urandom_range(200000, 0)) - 100000;
                end
                load_b();
        endtask

        // ring and model both keep x from the previous run
        task automatic test_warm_start();
                load_random_b();
                run_and_check(3, 2, 1, -1, 0, -1);
                report_test("warm start");
        endtask

        task automatic test_back_pressure();
                load_random_b();
                run_and_check(1, 1, 1, 1, 9, -1);
                assert (timed_out || max_outstanding == `OUT_CREDITS) else begin
                        $display("MISMATCH words outstanding got 0x%0h expected 0x%0h",
                                 max_outstanding, `OUT_CREDITS);
                        error_count++;
                end
                report_test("back-pressure");
        endtask

        task automatic test_start_while_busy();
                load_random_b();
                run_and_check(2, -1, 2, 1, 0, 40);
                report_test("start while busy");
        endtask

        initial begin
                void'($urandom(54));
                rst       = 1'b1;
                b_valid_i = 1'b0;
                b_data_i  = '0;
                start_i   = 1'b0;
                sweeps_i  = '0;
                c1_i      = '0;
                c2_i      = '0;
                c3_i      = '0;
                credit_i  = 1'b0;
                error_count   = 0;
                errors_before = 0;
                tests_run     = 0;
                tests_failed  = 0;
                timed_out     = 1'b0;
                for (int i = 0; i < N; i++) begin
                        x_model[i] = 0;
                        b_model[i] = 0;
                end
                repeat (8) @(posedge clk);
                @(negedge clk);
                rst = 1'b0;
                test_zero_sweeps();
                if (!timed_out) test_one_sweep();
                if (!timed_out) test_saturation();
                if (!timed_out) test_warm_start();
                if (!timed_out) test_back_pressure();
                if (!timed_out) test_start_while_busy();
                $display("tests run %0d, tests failed %0d, failing checks %0d",
                         tests_run, tests_failed, error_count);
                if (error_count == 0 && !timed_out) begin
                        $display("All tests passed!");
                end else begin
                        $display("Test failures found");
                end
                $finish;
        end

endmodule

`default_nettype wire

//--- band_solver.f
+incdir+include
verilog/solver_pkg.sv
verilog/step_counter.sv
verilog/x_ring.sv
verilog/update_unit.sv
verilog/sweep_ctrl.sv
verilog/band_solver.sv
dv/band_solver_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the band_solver testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
        -f band_solver.f --top-module band_solver_tb \
        > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

# a crashed or aborted simulation counts as a failure too
./obj_dir/Vband_solver_tb > "$LOG" 2>&1 || echo "Test failures found" >> "$LOG"

cat "$LOG"

grep -q "Test failures found" "$LOG" && { echo "simulation FAILED"; exit 1; }

echo "simulation passed"
exit 0
